//--- Makefile
SOURCES := $(shell grep -v '^+' sources.f) design/uart_rx_config.svh

.PHONY: run clean

run: obj_dir/Vtb_apb_uart_rx
	@out="$$(./obj_dir/Vtb_apb_uart_rx)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

obj_dir/Vtb_apb_uart_rx: sources.f $(SOURCES)
	verilator --binary --timing -j 0 --top-module tb_apb_uart_rx -f sources.f

clean:
	rm -rf obj_dir

//--- design/apb_uart_regs.sv
`timescale 1ns/10ps
`include "uart_rx_config.svh"

module apb_uart_regs
  import uart_rx_pkg::*;
(
  input  logic       tb_clk,
  input  logic       arst_n,
  input  apb_req_t   apb_req,
  output apb_rsp_t   apb_rsp,
  input  rx_status_t status,
  output uart_cfg_t  cfg,
  output logic       data_read,
  output logic       err_read
);

  // ****************************************
  // Access phase decode
  // ****************************************
  logic                      access;
  logic                      rd_access;
  logic                      wr_access;
  logic                      addr_valid;
  logic                      addr_ro;
  logic [`UART_DATA_W-1:0]   rd_data;
  logic [`UART_PERIOD_W-1:0] bit_period_q;
  logic [`UART_SIZE_W-1:0]   data_size_q;

  // Zero wait states, so the access phase is a single cycle
  assign access    = apb_req.psel & apb_req.penable;
  assign rd_access = access & ~apb_req.pwrite;
  assign wr_access = access & apb_req.pwrite;

  // Mapped addresses 0..4 and 6
  always_comb
  begin
    addr_valid = 1'b1;
    addr_ro    = 1'b0;
    case (apb_req.paddr)
      `UART_ADDR_DATA_SR,
      `UART_ADDR_ERROR_SR,
      `UART_ADDR_RX_DATA:
      begin
        addr_ro = 1'b1;
      end
      `UART_ADDR_BIT_CR0,
      `UART_ADDR_BIT_CR1,
      `UART_ADDR_DATA_CR:
      begin
        addr_ro = 1'b0;
      end
      default:
      begin
        addr_valid = 1'b0;
      end
    endcase
  end

  // ****************************************
  // Config registers
  // ****************************************
  // Write lands on the edge closing the access phase
  always_ff @(posedge tb_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      bit_period_q <= `UART_RESET_PERIOD;
      data_size_q  <= `UART_RESET_SIZE;
    end
    else if (wr_access)
    begin
      case (apb_req.paddr)
        `UART_ADDR_BIT_CR0:
          bit_period_q[`UART_DATA_W-1:0] <= apb_req.pwdata;
        // High byte only carries the top 6 bits of the period
        `UART_ADDR_BIT_CR1:
          bit_period_q[`UART_PERIOD_W-1:`UART_DATA_W] <=
            apb_req.pwdata[`UART_PERIOD_W-`UART_DATA_W-1:0];
        `UART_ADDR_DATA_CR:
          data_size_q <= apb_req.pwdata[`UART_SIZE_W-1:0];
        default:
        begin
        end
      endcase
    end
  end

  assign cfg.bit_period = bit_period_q;
  assign cfg.data_size  = data_size_q;

  // ****************************************
  // Read mux and response
  // ****************************************
  // Status values are the ones before any read-clear
  always_comb
  begin
    rd_data = '0;
    case (apb_req.paddr)
      `UART_ADDR_DATA_SR:
        rd_data[0] = status.data_ready;
      `UART_ADDR_ERROR_SR:
        rd_data[1:0] = {status.overrun_error, status.framing_error};
      `UART_ADDR_BIT_CR0:
        rd_data = bit_period_q[`UART_DATA_W-1:0];
      `UART_ADDR_BIT_CR1:
        rd_data[`UART_PERIOD_W-`UART_DATA_W-1:0] =
          bit_period_q[`UART_PERIOD_W-1:`UART_DATA_W];
      `UART_ADDR_DATA_CR:
        rd_data[`UART_SIZE_W-1:0] = data_size_q;
      `UART_ADDR_RX_DATA:
        rd_data = status.rx_data;
      default:
        rd_data = '0;
    endcase
  end

  assign apb_rsp.prdata = rd_access ? rd_data : '0;

  // Error on unmapped address, or a write to a status/data register
  assign apb_rsp.pslverr = access & (~addr_valid | (apb_req.pwrite & addr_ro));

  // Read-clear strobes, one cycle wide
  assign data_read = rd_access & (apb_req.paddr == `UART_ADDR_RX_DATA);
  assign err_read  = rd_access & (apb_req.paddr == `UART_ADDR_ERROR_SR);

endmodule

//--- design/apb_uart_rx.sv
`timescale 1ns/10ps

module apb_uart_rx
  import uart_rx_pkg::*;
(
  input  logic     tb_clk,
  input  logic     arst_n,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp,
  input  logic     serial_in
);

  // ****************************************
  // Internal wiring
  // ****************************************
  uart_cfg_t  cfg;
  rx_frame_t  frame;
  rx_status_t status;
  logic       frame_done;
  logic       data_read;
  logic       err_read;

  // Bus side, config and status readback
  apb_uart_regs apb_uart_regs_inst (
    .tb_clk    (tb_clk),
    .arst_n    (arst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .status    (status),
    .cfg       (cfg),
    .data_read (data_read),
    .err_read  (err_read)
  );

  // Serial line to frames
  uart_rx_framer uart_rx_framer_inst (
    .tb_clk     (tb_clk),
    .arst_n     (arst_n),
    .cfg        (cfg),
    .serial_in  (serial_in),
    .frame      (frame),
    .frame_done (frame_done)
  );

  // One-entry holding stage
  rx_status_buffer rx_status_buffer_inst (
    .tb_clk     (tb_clk),
    .arst_n     (arst_n),
    .frame      (frame),
    .frame_done (frame_done),
    .data_read  (data_read),
    .err_read   (err_read),
    .status     (status)
  );

endmodule

//--- design/rx_status_buffer.sv
`timescale 1ns/10ps

module rx_status_buffer
  import uart_rx_pkg::*;
(
  input  logic       tb_clk,
  input  logic       arst_n,
  input  rx_frame_t  frame,
  input  logic       frame_done,
  input  logic       data_read,
  input  logic       err_read,
  output rx_status_t status
);

  logic good_frame;
  logic bad_frame;
  logic lost_frame;

  // ****************************************
  // Frame outcome
  // ****************************************
  assign good_frame = frame_done & frame.stop_bit;
  assign bad_frame  = frame_done & ~frame.stop_bit;

  // Old byte still unread, and no read in this same cycle
  assign lost_frame = good_frame & status.data_ready & ~data_read;

  // ****************************************
  // Holding register and sticky flags
  // ****************************************
  // A set beats a clear in the same cycle
  always_ff @(posedge tb_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      status <= '0;
    end
    else
    begin
      // Bad frame leaves rx_data as it was
      if (good_frame)
        status.rx_data <= frame.data;

      if (good_frame)
        status.data_ready <= 1'b1;
      else if (data_read)
        status.data_ready <= 1'b0;

      if (lost_frame)
        status.overrun_error <= 1'b1;
      else if (err_read)
        status.overrun_error <= 1'b0;

      if (bad_frame)
        status.framing_error <= 1'b1;
      else if (err_read)
        status.framing_error <= 1'b0;
    end
  end

endmodule

//--- design/uart_rx_config.svh
`ifndef UART_RX_CONFIG_SVH
`define UART_RX_CONFIG_SVH

// APB bus widths
`define UART_ADDR_W        3
`define UART_DATA_W        8

// Receiver configuration widths
`define UART_PERIOD_W      14
`define UART_SIZE_W        4
`define UART_MAX_DATA      8

// Register map
`define UART_ADDR_DATA_SR  3'd0
`define UART_ADDR_ERROR_SR 3'd1
`define UART_ADDR_BIT_CR0  3'd2
`define UART_ADDR_BIT_CR1  3'd3
`define UART_ADDR_DATA_CR  3'd4
`define UART_ADDR_RX_DATA  3'd6

// Out of reset the receiver runs at 10 clocks per bit, 8 data bits
`define UART_RESET_PERIOD  14'd10
`define UART_RESET_SIZE    4'd8

// serial_in synchronizer depth
`define UART_SYNC_STAGES   2

`endif

//--- design/uart_rx_framer.sv
`timescale 1ns/10ps
`include "uart_rx_config.svh"

module uart_rx_framer
  import uart_rx_pkg::*;
(
  input  logic      tb_clk,
  input  logic      arst_n,
  input  uart_cfg_t cfg,
  input  logic      serial_in,
  output rx_frame_t frame,
  output logic      frame_done
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_STOP
  } rx_state_t;

  rx_state_t                   state_q;
  logic [`UART_SYNC_STAGES-1:0] sync_q;
  logic                        line;
  logic                        line_q;
  logic                        falling;
  logic [`UART_PERIOD_W-1:0]   cnt_q;
  logic [`UART_PERIOD_W-1:0]   period_q;
  logic                        tick;
  logic [`UART_SIZE_W-1:0]     eff_size;
  logic [`UART_SIZE_W-1:0]     size_q;
  logic [`UART_SIZE_W-1:0]     bit_cnt_q;
  logic                        last_bit;
  logic [`UART_MAX_DATA-1:0]   shift_q;
  logic                        stop_q;
  logic                        done_q;

  // ****************************************
  // Synchronizer and edge detect
  // ****************************************
  // Idle level is high, so reset the chain to ones
  always_ff @(posedge tb_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sync_q <= '1;
      line_q <= 1'b1;
    end
    else
    begin
      sync_q <= {sync_q[`UART_SYNC_STAGES-2:0], serial_in};
      line_q <= line;
    end
  end

  assign line    = sync_q[`UART_SYNC_STAGES-1];
  assign falling = line_q & ~line;

  // Sizes outside 1..8 are clamped
  always_comb
  begin
    if (cfg.data_size > `UART_SIZE_W'(`UART_MAX_DATA))
      eff_size = `UART_SIZE_W'(`UART_MAX_DATA);
    else if (cfg.data_size == '0)
      eff_size = `UART_SIZE_W'(1);
    else
      eff_size = cfg.data_size;
  end

  // Bit-center tick from the down-counter
  assign tick     = (cnt_q <= `UART_PERIOD_W'(1));
  assign last_bit = (bit_cnt_q == size_q - `UART_SIZE_W'(1));

  // ****************************************
  // Frame FSM
  // ****************************************
  always_ff @(posedge tb_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q   <= ST_IDLE;
      cnt_q     <= '0;
      period_q  <= `UART_RESET_PERIOD;
      size_q    <= `UART_RESET_SIZE;
      bit_cnt_q <= '0;
      stop_q    <= 1'b1;
      done_q    <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      if (state_q != ST_IDLE && !tick)
        cnt_q <= cnt_q - `UART_PERIOD_W'(1);
      case (state_q)
        ST_IDLE:
        begin
          // New config is taken only here, at a start edge
          if (falling)
          begin
            period_q <= cfg.bit_period;
            size_q   <= eff_size;
            cnt_q    <= cfg.bit_period >> 1;
            state_q  <= ST_START;
          end
        end
        ST_START:
        begin
          // Mid start bit, line must still be low
          if (tick)
          begin
            cnt_q     <= period_q;
            bit_cnt_q <= '0;
            state_q   <= line ? ST_IDLE : ST_DATA;
          end
        end
        ST_DATA:
        begin
          if (tick)
          begin
            cnt_q     <= period_q;
            bit_cnt_q <= bit_cnt_q + `UART_SIZE_W'(1);
            if (last_bit)
              state_q <= ST_STOP;
          end
        end
        ST_STOP:
        begin
          if (tick)
          begin
            stop_q  <= line;
            done_q  <= 1'b1;
            state_q <= ST_IDLE;
          end
        end
        default:
          state_q <= ST_IDLE;
      endcase
    end
  end

  // ****************************************
  // Data shift register
  // ****************************************
  // LSB arrives first, enters at the top and moves down
  always_ff @(posedge tb_clk)
  begin
    if (state_q == ST_DATA && tick)
      shift_q <= {line, shift_q[`UART_MAX_DATA-1:1]};
  end

  // Right-justify, upper bits fill with zero
  assign frame.data     = shift_q >> (`UART_SIZE_W'(`UART_MAX_DATA) - size_q);
  assign frame.stop_bit = stop_q;
  assign frame_done     = done_q;

endmodule

//--- design/uart_rx_pkg.sv
`include "uart_rx_config.svh"

package uart_rx_pkg;

  // ****************************************
  // APB request and response
  // ****************************************
  typedef struct packed {
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`UART_ADDR_W-1:0] paddr;
    logic [`UART_DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`UART_DATA_W-1:0] prdata;
    logic                    pslverr;
  } apb_rsp_t;

  // ****************************************
  // Receiver side
  // ****************************************
  // Line settings from the config registers
  typedef struct packed {
    logic [`UART_PERIOD_W-1:0] bit_period;
    logic [`UART_SIZE_W-1:0]   data_size;
  } uart_cfg_t;

  // One received frame, data right-justified
  typedef struct packed {
    logic [`UART_MAX_DATA-1:0] data;
    logic                      stop_bit;
  } rx_frame_t;

  // Holding register plus sticky flags
  typedef struct packed {
    logic [`UART_MAX_DATA-1:0] rx_data;
    logic                      data_ready;
    logic                      overrun_error;
    logic                      framing_error;
  } rx_status_t;

endpackage

//--- dv/tb_apb_uart_rx.sv
`timescale 1ns/10ps
`include "uart_rx_config.svh"

module tb_apb_uart_rx
  import uart_rx_pkg::*;
();

  // One row per test
  typedef struct packed {
    logic [8*12-1:0]           name;
    logic [`UART_PERIOD_W-1:0] bit_period;
    logic [`UART_SIZE_W-1:0]   data_size;
    logic [`UART_MAX_DATA-1:0] pattern;
    logic                      use_random;
    logic                      stop_bit;
    logic                      back_to_back;
    logic [`UART_ADDR_W-1:0]   probe_addr;
  } test_row_t;

  localparam int NUM_TESTS = 6;

  // name, period, size, pattern, random, stop, back-to-back, probe address
  test_row_t tests [NUM_TESTS] = '{
    '{"good_p10_s8 ", 14'd10, 4'd8, 8'hA5, 1'b0, 1'b1, 1'b0, 3'd6},
    '{"rand_p16_s5 ", 14'd16, 4'd5, 8'h00, 1'b1, 1'b1, 1'b0, 3'd5},
    '{"frame_p37_s7", 14'd37, 4'd7, 8'hDC, 1'b0, 1'b0, 1'b0, 3'd4},
    '{"ovrun_p16_s7", 14'd16, 4'd7, 8'h00, 1'b1, 1'b1, 1'b1, 3'd6},
    '{"rand_p37_s8 ", 14'd37, 4'd8, 8'h00, 1'b1, 1'b1, 1'b0, 3'd5},
    '{"ovrun_p10_s5", 14'd10, 4'd5, 8'h16, 1'b0, 1'b1, 1'b1, 3'd4}
  };

  logic                    tb_clk;
  logic                    arst_n;
  apb_req_t                apb_req;
  apb_rsp_t                apb_rsp;
  logic                    serial_in;
  logic [`UART_DATA_W-1:0] exp_prdata;
  logic                    exp_pslverr;
  logic                    test_end;
  logic [8*12-1:0]         test_name;
  int                      total_checks;
  int                      total_errors;
  logic [15:0]             lfsr_q;

  apb_uart_rx apb_uart_rx_inst (
    .tb_clk    (tb_clk),
    .arst_n    (arst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .serial_in (serial_in)
  );

  uart_rx_checker uart_rx_checker_inst (
    .tb_clk       (tb_clk),
    .arst_n       (arst_n),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .exp_prdata   (exp_prdata),
    .exp_pslverr  (exp_pslverr),
    .test_end     (test_end),
    .test_name    (test_name),
    .total_checks (total_checks),
    .total_errors (total_errors)
  );

  // 100 ns clock
  initial
  begin
    tb_clk = 1'b0;
    forever #50 tb_clk = ~tb_clk;
  end

  // ****************************************
  // Helpers
  // ****************************************
  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  // Keep only the bits that were actually on the line
  function automatic logic [7:0] mask_to_size(input logic [7:0] data, input logic [3:0] size);
    logic [7:0] mask;
    int         i;
    for (i = 0; i < 8; i++)
      mask[i] = (i < int'(size));
    return data & mask;
  endfunction

  // Per row: frame bits plus margin, doubled, and room for the register traffic
  function automatic int watchdog_cycles();
    int total;
    int i;
    total = 0;
    for (i = 0; i < NUM_TESTS; i++)
      total += (int'(tests[i].data_size) + 4) * int'(tests[i].bit_period) * 2 + 200;
    return total;
  endfunction

  // One LFSR step per data bit
  task automatic take_random(input logic [3:0] size, output logic [7:0] bits);
    int i;
    bits = '0;
    for (i = 0; i < int'(size); i++)
    begin
      lfsr_q  = lfsr_next(lfsr_q);
      bits[i] = lfsr_q[0];
    end
  endtask

  // Setup then access phase, no wait states
  task automatic apb_transfer(input logic write, input logic [2:0] addr,
                              input logic [7:0] wdata, input logic [7:0] exp_data,
                              input logic exp_err);
    exp_prdata      <= exp_data;
    exp_pslverr     <= exp_err;
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= write;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge tb_clk);
    apb_req.penable <= 1'b1;
    @(posedge tb_clk);
    apb_req <= '0;
  endtask

  task automatic apb_write(input logic [2:0] addr, input logic [7:0] data, input logic exp_err);
    apb_transfer(1'b1, addr, data, 8'h00, exp_err);
  endtask

  task automatic apb_read(input logic [2:0] addr, input logic [7:0] exp_data,
                          input logic exp_err);
    apb_transfer(1'b0, addr, 8'h00, exp_data, exp_err);
  endtask

  // Start bit, data LSB first, stop bit, each held one bit period
  task automatic send_frame(input logic [7:0] data, input logic [3:0] size,
                            input logic [13:0] period, input logic stop);
    int i;
    serial_in <= 1'b0;
    repeat (period) @(posedge tb_clk);
    for (i = 0; i < int'(size); i++)
    begin
      serial_in <= data[i];
      repeat (period) @(posedge tb_clk);
    end
    serial_in <= stop;
    repeat (period) @(posedge tb_clk);
    serial_in <= 1'b1;
  endtask

  task automatic finish_test();
    test_end <= 1'b1;
    @(posedge tb_clk);
    test_end <= 1'b0;
  endtask

  // Address 6 is read-only, 5 is unmapped, 4 is a valid read
  task automatic probe_slave_error(input logic [2:0] addr, input logic [3:0] size);
    case (addr)
      3'd6:
        apb_write(addr, 8'hFF, 1'b1);
      3'd4:
        apb_read(addr, {4'h0, size}, 1'b0);
      default:
        apb_read(addr, 8'h00, 1'b1);
    endcase
  endtask

  // ****************************************
  // One table row
  // ****************************************
  task automatic run_row(input test_row_t row);
    logic [7:0] first;
    logic [7:0] second;
    // High byte holds only the top 6 bits of the period
    apb_write(`UART_ADDR_BIT_CR1, 8'hFF, 1'b0);
    apb_read(`UART_ADDR_BIT_CR1, 8'h3F, 1'b0);
    // Config round trip
    apb_write(`UART_ADDR_BIT_CR0, row.bit_period[7:0], 1'b0);
    apb_write(`UART_ADDR_BIT_CR1, {2'b00, row.bit_period[13:8]}, 1'b0);
    apb_write(`UART_ADDR_DATA_CR, {4'h0, row.data_size}, 1'b0);
    apb_read(`UART_ADDR_BIT_CR0, row.bit_period[7:0], 1'b0);
    apb_read(`UART_ADDR_BIT_CR1, {2'b00, row.bit_period[13:8]}, 1'b0);
    apb_read(`UART_ADDR_DATA_CR, {4'h0, row.data_size}, 1'b0);
    if (row.use_random)
      take_random(row.data_size, first);
    else
      first = row.pattern;
    send_frame(first, row.data_size, row.bit_period, row.stop_bit);
    second = first;
    // Second frame lands on an unread byte
    if (row.back_to_back)
    begin
      if (row.use_random)
        take_random(row.data_size, second);
      else
        second = ~row.pattern;
      send_frame(second, row.data_size, row.bit_period, 1'b1);
    end
    repeat (2 * int'(row.bit_period)) @(posedge tb_clk);
    if (!row.stop_bit)
    begin
      apb_read(`UART_ADDR_ERROR_SR, 8'h01, 1'b0);
      apb_read(`UART_ADDR_DATA_SR, 8'h00, 1'b0);
      apb_read(`UART_ADDR_ERROR_SR, 8'h00, 1'b0);
    end
    else
    begin
      apb_read(`UART_ADDR_DATA_SR, 8'h01, 1'b0);
      apb_read(`UART_ADDR_ERROR_SR, row.back_to_back ? 8'h02 : 8'h00, 1'b0);
      apb_read(`UART_ADDR_RX_DATA, mask_to_size(second, row.data_size), 1'b0);
      apb_read(`UART_ADDR_DATA_SR, 8'h00, 1'b0);
      apb_read(`UART_ADDR_ERROR_SR, 8'h00, 1'b0);
    end
    probe_slave_error(row.probe_addr, row.data_size);
  endtask

  // ****************************************
  // Main sequence
  // ****************************************
  initial
  begin : main_sequence
    int i;
    arst_n      = 1'b0;
    apb_req     = '0;
    serial_in   = 1'b1;
    exp_prdata  = '0;
    exp_pslverr = 1'b0;
    test_end    = 1'b0;
    test_name   = '0;
    lfsr_q      = 16'd3202;
    repeat (5) @(posedge tb_clk);
    arst_n <= 1'b1;
    @(posedge tb_clk);
    // Reset values
    test_name <= "reset_values";
    apb_read(`UART_ADDR_BIT_CR0, 8'h0A, 1'b0);
    apb_read(`UART_ADDR_BIT_CR1, 8'h00, 1'b0);
    apb_read(`UART_ADDR_DATA_CR, 8'h08, 1'b0);
    apb_read(`UART_ADDR_DATA_SR, 8'h00, 1'b0);
    apb_read(`UART_ADDR_ERROR_SR, 8'h00, 1'b0);
    apb_read(`UART_ADDR_RX_DATA, 8'h00, 1'b0);
    finish_test();
    for (i = 0; i < NUM_TESTS; i++)
    begin
      test_name <= tests[i].name;
      run_row(tests[i]);
      finish_test();
    end
    @(negedge tb_clk);
    $display("Total: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0 && total_checks > 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  // Watchdog
  initial
  begin : watchdog
    int limit;
    limit = watchdog_cycles();
    repeat (limit) @(posedge tb_clk);
    $display("Timeout: the tests did not finish within %0d clock cycles", limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- dv/uart_rx_checker.sv
`timescale 1ns/10ps
`include "uart_rx_config.svh"

module uart_rx_checker
  import uart_rx_pkg::*;
(
  input  logic                    tb_clk,
  input  logic                    arst_n,
  input  apb_req_t                apb_req,
  input  apb_rsp_t                apb_rsp,
  input  logic [`UART_DATA_W-1:0] exp_prdata,
  input  logic                    exp_pslverr,
  input  logic                    test_end,
  input  logic [8*12-1:0]         test_name,
  output int                      total_checks,
  output int                      total_errors
);

  int n_checks = 0;
  int n_errors = 0;
  int test_checks = 0;
  int test_errors = 0;

  assign total_checks = n_checks;
  assign total_errors = n_errors;

  // ****************************************
  // Access phase compare
  // ****************************************
  // Sampled on the edge that closes the access phase, before any read-clear lands
  always @(posedge tb_clk)
  begin
    if (arst_n && apb_req.psel && apb_req.penable)
    begin
      n_checks    = n_checks + 1;
      test_checks = test_checks + 1;
      if (apb_rsp.pslverr !== exp_pslverr)
      begin
        $display("** Error: apb_rsp.pslverr = 0x%0h, expected 0x%0h (paddr 0x%0h, %s)",
                 apb_rsp.pslverr, exp_pslverr, apb_req.paddr,
                 apb_req.pwrite ? "write" : "read");
        n_errors    = n_errors + 1;
        test_errors = test_errors + 1;
      end
      // Read data only matters on reads
      if (!apb_req.pwrite && apb_rsp.prdata !== exp_prdata)
      begin
        $display("** Error: apb_rsp.prdata = 0x%02h, expected 0x%02h (paddr 0x%0h)",
                 apb_rsp.prdata, exp_prdata, apb_req.paddr);
        n_errors    = n_errors + 1;
        test_errors = test_errors + 1;
      end
    end
    // One summary line per finished test
    if (test_end)
    begin
      $display("%s : %0d checks, %0d errors, %s", test_name, test_checks, test_errors,
               (test_errors == 0) ? "passed" : "failed");
      test_checks = 0;
      test_errors = 0;
    end
  end

endmodule

//--- sources.f
+incdir+design
design/uart_rx_pkg.sv
design/apb_uart_regs.sv
design/uart_rx_framer.sv
design/rx_status_buffer.sv
design/apb_uart_rx.sv
dv/uart_rx_checker.sv
dv/tb_apb_uart_rx.sv
